// File: bus_fabric.f
bus_pkg.sv
bus_arbiter_ctrl.sv
master_mux.sv
slave_decoder.sv
reg_bank_slave.sv
bus_fabric.sv
bus_fabric_sva.sv
bus_fabric_tb.sv

// File: bus_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric_tb;

  localparam int CLK_HALF = 4;
  // idle bus: grant, slave sample, response
  localparam int IDLE_LAT = 3;
  // longest legal wait on one transfer
  localparam int MAX_WAIT = 12;
  localparam int MAX_XFERS = 200;
  // all transfers at worst case plus reset and gap cycles
  localparam int WATCHDOG_NS = (MAX_XFERS * MAX_WAIT + 100) * 2 * CLK_HALF;
  localparam int PER_SLAVE = 4;
  localparam int ROUNDS = 4;

  logic clk;
  logic rstN;
  bus_pkg::wb_req_t m0_req;
  bus_pkg::wb_req_t m1_req;
  bus_pkg::wb_rsp_t m0_rsp;
  bus_pkg::wb_rsp_t m1_rsp;

  logic [31:0] lfsr;
  // expected slave contents, row 0 unused
  logic [bus_pkg::DATA_W-1:0] ref_mem [4][bus_pkg::NUM_WORDS];
  // words left by master 0 for master 1 to read
  bus_pkg::bus_addr_u m0_addrs[$];
  int val_errs;
  int proto_errs;

  bus_fabric dut (
    .clk    (clk),
    .rstN   (rstN),
    .m0_req (m0_req),
    .m1_req (m1_req),
    .m0_rsp (m0_rsp),
    .m1_rsp (m1_rsp)
  );

  always #CLK_HALF clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // stimulus source
  //////////////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [bus_pkg::DATA_W-1:0] rand_word();
    logic [bus_pkg::DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < bus_pkg::DATA_W; i++) begin
      v = {v[bus_pkg::DATA_W-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [bus_pkg::OFS_W-1:0] rand_ofs();
    logic [bus_pkg::OFS_W-1:0] v;
    v = '0;
    for (int i = 0; i < bus_pkg::OFS_W; i++) begin
      v = {v[bus_pkg::OFS_W-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // master driver
  //////////////////////////////////////////////////////////////////////

  // one classic single transfer, called just after a rising edge
  task automatic xfer(input logic mst, input logic we, input bus_pkg::bus_addr_u adr,
                      input logic [bus_pkg::DATA_W-1:0] wdat, input string name,
                      output bus_pkg::wb_rsp_t rsp, output int lat);
    bus_pkg::wb_req_t req;
    logic exp_ack;
    req = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we = we;
    req.adr = adr;
    req.dat = wdat;
    // slave id 0 has nothing behind it
    exp_ack = (adr.f.slv != 2'd0);
    if (mst) begin
      m1_req = req;
    end else begin
      m0_req = req;
    end
    lat = 0;
    rsp = '0;
    while (!(rsp.ack || rsp.err) && lat < MAX_WAIT) begin
      @(posedge clk);
      lat++;
      // mid cycle, response settled
      @(negedge clk);
      rsp = mst ? m1_rsp : m0_rsp;
    end
    if (!(rsp.ack || rsp.err)) begin
      $display("%s: master %0d got neither ack nor err in time", name, mst);
      proto_errs++;
    end else if (rsp.ack !== exp_ack || rsp.err !== !exp_ack) begin
      $display("Fail %s ack/err: expected %b%b, actual %b%b",
               name, exp_ack, !exp_ack, rsp.ack, rsp.err);
      val_errs++;
    end
    // master takes the response on this edge
    @(posedge clk);
    lat++;
    #1;
    if (mst) begin
      m1_req = '0;
    end else begin
      m0_req = '0;
    end
    // one quiet cycle, fsm back in idle
    @(posedge clk);
    #1;
  endtask

  task automatic wb_write(input logic mst, input bus_pkg::bus_addr_u adr,
                          input logic [bus_pkg::DATA_W-1:0] wdat, input string name,
                          output int lat);
    bus_pkg::wb_rsp_t rsp;
    xfer(mst, 1'b1, adr, wdat, name, rsp, lat);
    // write lands with the ack
    if (rsp.ack) begin
      ref_mem[adr.f.slv][adr.f.ofs] = wdat;
    end
  endtask

  task automatic wb_read(input logic mst, input bus_pkg::bus_addr_u adr, input string name,
                         output int lat);
    bus_pkg::wb_rsp_t rsp;
    xfer(mst, 1'b0, adr, '0, name, rsp, lat);
    if (rsp.ack && rsp.dat !== ref_mem[adr.f.slv][adr.f.ofs]) begin
      $display("Fail %s read: expected %h, actual %h",
               name, ref_mem[adr.f.slv][adr.f.ofs], rsp.dat);
      val_errs++;
    end
  endtask

  task automatic check_idle_lat(input string name, input int lat);
    if (lat != IDLE_LAT) begin
      $display("Fail %s latency: expected %0d, actual %0d", name, IDLE_LAT, lat);
      val_errs++;
    end
  endtask

  // no response may show up on a quiet bus
  task automatic check_quiet(input string name);
    if (m0_rsp.ack || m0_rsp.err || m1_rsp.ack || m1_rsp.err) begin
      $display("%s: response seen on a master port with no request", name);
      proto_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic do_reset();
    rstN = 1'b0;
    m0_req = '0;
    m1_req = '0;
    // slaves come up all zero
    for (int s = 0; s < 4; s++) begin
      for (int w = 0; w < bus_pkg::NUM_WORDS; w++) begin
        ref_mem[s][w] = '0;
      end
    end
    repeat (3) begin
      @(posedge clk);
      #1;
      check_quiet("reset");
    end
    rstN = 1'b1;
    @(posedge clk);
    #1;
    check_quiet("after reset");
  endtask

  // writes to every slave, read back, master 1 also reads master 0's words
  task automatic test_master(input logic mst, input string name);
    bus_pkg::bus_addr_u adr;
    bus_pkg::bus_addr_u done_q[$];
    int lat;
    for (int s = 1; s <= bus_pkg::NUM_SLAVES; s++) begin
      repeat (PER_SLAVE) begin
        adr.f.slv = 2'(s);
        adr.f.ofs = rand_ofs();
        wb_write(mst, adr, rand_word(), name, lat);
        check_idle_lat(name, lat);
        done_q.push_back(adr);
      end
    end
    foreach (done_q[i]) begin
      wb_read(mst, done_q[i], name, lat);
      check_idle_lat(name, lat);
    end
    if (mst) begin
      foreach (m0_addrs[i]) begin
        wb_read(1'b1, m0_addrs[i], "shared slaves", lat);
      end
    end else begin
      m0_addrs = done_q;
    end
  endtask

  task automatic test_unmapped();
    bus_pkg::bus_addr_u adr;
    int lat;
    adr.f.slv = 2'd0;
    adr.f.ofs = rand_ofs();
    wb_write(1'b0, adr, rand_word(), "unmapped write", lat);
    check_idle_lat("unmapped write", lat);
    wb_read(1'b1, adr, "unmapped read", lat);
    check_idle_lat("unmapped read", lat);
    // same offset in slave 1 stays as it was
    adr.f.slv = 2'd1;
    wb_read(1'b0, adr, "unmapped then slave 1", lat);
  endtask

  task automatic test_contention();
    bus_pkg::bus_addr_u a0;
    bus_pkg::bus_addr_u a1;
    bus_pkg::bus_addr_u a0_q[$];
    bus_pkg::bus_addr_u a1_q[$];
    bus_pkg::bus_addr_u used_q[$];
    logic [bus_pkg::DATA_W-1:0] d0_q[$];
    logic [bus_pkg::DATA_W-1:0] d1_q[$];
    logic order[$];
    logic exp_order[$];
    logic last;
    int lat0;
    int lat1;
    do_reset();
    // addresses and data drawn up front, one fixed lfsr sequence
    repeat (ROUNDS) begin
      a0.f.slv = 2'd3;
      a0.f.ofs = rand_ofs();
      a1.f.slv = 2'd3;
      a1.f.ofs = rand_ofs();
      a0_q.push_back(a0);
      a1_q.push_back(a1);
      d0_q.push_back(rand_word());
      d1_q.push_back(rand_word());
      used_q.push_back(a0);
      used_q.push_back(a1);
    end
    // both masters keep asking, grant goes to whoever was not served last
    // after reset master 1 counts as served last
    last = 1'b1;
    repeat (2 * ROUNDS) begin
      exp_order.push_back(~last);
      last = ~last;
    end
    // first requests raised together, each master asks again right after its ack
    fork
      begin
        foreach (a0_q[i]) begin
          wb_write(1'b0, a0_q[i], d0_q[i], "contention m0", lat0);
          order.push_back(1'b0);
        end
      end
      begin
        foreach (a1_q[i]) begin
          wb_write(1'b1, a1_q[i], d1_q[i], "contention m1", lat1);
          order.push_back(1'b1);
        end
      end
    join
    if (order.size() != exp_order.size()) begin
      $display("contention: %0d transfers finished out of %0d", order.size(),
               exp_order.size());
      proto_errs++;
    end
    foreach (exp_order[i]) begin
      if (order[i] !== exp_order[i]) begin
        $display("Fail contention order %0d: expected %0d, actual %0d",
                 i, exp_order[i], order[i]);
        val_errs++;
      end
    end
    foreach (used_q[i]) begin
      wb_read(1'b0, used_q[i], "contention readback", lat0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    m0_req = '0;
    m1_req = '0;
    lfsr = 32'he929;
    val_errs = 0;
    proto_errs = 0;
    do_reset();
    test_master(1'b0, "master 0 access");
    test_master(1'b1, "master 1 access");
    test_unmapped();
    test_contention();
    $display("value errors %0d, protocol errors %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule : bus_fabric_tb

`default_nettype wire

// File: bus_fabric_sva.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric_sva (
  input logic              clk,
  input logic              rstN,
  input bus_pkg::wb_req_t  m0_req,
  input bus_pkg::wb_req_t  m1_req,
  input bus_pkg::wb_rsp_t  m0_rsp,
  input bus_pkg::wb_rsp_t  m1_rsp,
  input bus_pkg::wb_rsp_t  bus_rsp
);

  logic m0_hit;
  logic m1_hit;

  // any response on a master port
  assign m0_hit = m0_rsp.ack | m0_rsp.err;
  assign m1_hit = m1_rsp.ack | m1_rsp.err;

  // one owner sees the answer
  a_one_owner: assert property (@(posedge clk) disable iff (!rstN)
    !(m0_hit && m1_hit))
    else $error("response routed to both masters");

  // answer only to a master that is asking
  a_m0_asking: assert property (@(posedge clk) disable iff (!rstN)
    m0_hit |-> (m0_req.cyc && m0_req.stb))
    else $error("master 0 got a response without holding stb");

  a_m1_asking: assert property (@(posedge clk) disable iff (!rstN)
    m1_hit |-> (m1_req.cyc && m1_req.stb))
    else $error("master 1 got a response without holding stb");

  a_ack_xor_err: assert property (@(posedge clk) disable iff (!rstN)
    !(bus_rsp.ack && bus_rsp.err))
    else $error("ack and err high together on the shared bus");

endmodule : bus_fabric_sva

bind bus_fabric bus_fabric_sva u_sva (
  .clk     (clk),
  .rstN    (rstN),
  .m0_req  (m0_req),
  .m1_req  (m1_req),
  .m0_rsp  (m0_rsp),
  .m1_rsp  (m1_rsp),
  .bus_rsp (bus_rsp)
);

`default_nettype wire

// File: bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
  input  logic              clk,
  input  logic              rstN,
  input  bus_pkg::wb_req_t  m0_req,
  input  bus_pkg::wb_req_t  m1_req,
  output bus_pkg::wb_rsp_t  m0_rsp,
  output bus_pkg::wb_rsp_t  m1_rsp
);

  bus_pkg::bus_state_t bus_state;
  bus_pkg::wb_req_t bus_req;
  bus_pkg::wb_rsp_t bus_rsp;
  bus_pkg::wb_rsp_t s_rsp1;
  bus_pkg::wb_rsp_t s_rsp2;
  bus_pkg::wb_rsp_t s_rsp3;
  logic [bus_pkg::NUM_SLAVES-1:0] s_stb;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  bus_arbiter_ctrl u_ctrl (
    .clk       (clk),
    .rstN      (rstN),
    .m0_req    (m0_req),
    .m1_req    (m1_req),
    .bus_rsp   (bus_rsp),
    .bus_state (bus_state)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  // master side steering
  master_mux u_mmux (
    .bus_state (bus_state),
    .m0_req    (m0_req),
    .m1_req    (m1_req),
    .bus_rsp   (bus_rsp),
    .bus_req   (bus_req),
    .m0_rsp    (m0_rsp),
    .m1_rsp    (m1_rsp)
  );

  // slave side decode and merge
  slave_decoder u_dec (
    .clk     (clk),
    .rstN    (rstN),
    .bus_req (bus_req),
    .s_stb   (s_stb),
    .s_rsp1  (s_rsp1),
    .s_rsp2  (s_rsp2),
    .s_rsp3  (s_rsp3),
    .bus_rsp (bus_rsp)
  );

  // slave id 1
  reg_bank_slave u_slv1 (
    .clk     (clk),
    .rstN    (rstN),
    .stb     (s_stb[0]),
    .bus_req (bus_req),
    .rsp     (s_rsp1)
  );

  // slave id 2
  reg_bank_slave u_slv2 (
    .clk     (clk),
    .rstN    (rstN),
    .stb     (s_stb[1]),
    .bus_req (bus_req),
    .rsp     (s_rsp2)
  );

  // slave id 3
  reg_bank_slave u_slv3 (
    .clk     (clk),
    .rstN    (rstN),
    .stb     (s_stb[2]),
    .bus_req (bus_req),
    .rsp     (s_rsp3)
  );

endmodule : bus_fabric

`default_nettype wire

// File: reg_bank_slave.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank_slave (
  input  logic              clk,
  input  logic              rstN,
  // select from the decoder, already qualified by cyc and stb
  input  logic              stb,
  input  bus_pkg::wb_req_t  bus_req,
  output bus_pkg::wb_rsp_t  rsp
);

  logic [bus_pkg::DATA_W-1:0] mem [bus_pkg::NUM_WORDS];
  logic [bus_pkg::DATA_W-1:0] rdat;
  logic [bus_pkg::OFS_W-1:0] ofs;
  logic ack_q;
  logic hit;

  assign ofs = bus_req.adr.f.ofs;

  // no second ack while the first is still out
  assign hit = stb & ~ack_q;

  // storage and ack, contents cleared on reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ack_q <= 1'b0;
      for (int i = 0; i < bus_pkg::NUM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      ack_q <= hit;
      // write lands on the ack edge
      if (hit && bus_req.we) begin
        mem[ofs] <= bus_req.dat;
      end
    end
  end

  // read data captured with the ack
  always_ff @(posedge clk) begin
    if (hit && !bus_req.we) begin
      rdat <= mem[ofs];
    end
  end

  assign rsp.ack = ack_q;
  // register bank never errors
  assign rsp.err = 1'b0;
  assign rsp.dat = rdat;

endmodule : reg_bank_slave

`default_nettype wire

// File: slave_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module slave_decoder (
  input  logic                              clk,
  input  logic                              rstN,
  input  bus_pkg::wb_req_t                  bus_req,
  // bit 0 strobes slave id 1
  output logic [bus_pkg::NUM_SLAVES-1:0]    s_stb,
  input  bus_pkg::wb_rsp_t                  s_rsp1,
  input  bus_pkg::wb_rsp_t                  s_rsp2,
  input  bus_pkg::wb_rsp_t                  s_rsp3,
  output bus_pkg::wb_rsp_t                  bus_rsp
);

  logic active;
  logic unmapped;
  logic err_q;
  logic [bus_pkg::SLV_W-1:0] slv;

  assign active = bus_req.cyc & bus_req.stb;
  assign slv = bus_req.adr.f.slv;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  assign s_stb[0] = active & (slv == 2'd1);
  assign s_stb[1] = active & (slv == 2'd2);
  assign s_stb[2] = active & (slv == 2'd3);

  // id 0 has no slave behind it
  assign unmapped = active & (slv == 2'd0);

  // err one cycle after strobe, single pulse while stb is held
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped & ~err_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response merge
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_rsp.ack = s_rsp1.ack | s_rsp2.ack | s_rsp3.ack;
    bus_rsp.err = err_q | s_rsp1.err | s_rsp2.err | s_rsp3.err;
    // read data from the addressed slave
    unique case (slv)
      2'd1: bus_rsp.dat = s_rsp1.dat;
      2'd2: bus_rsp.dat = s_rsp2.dat;
      2'd3: bus_rsp.dat = s_rsp3.dat;
      default: bus_rsp.dat = '0;
    endcase
  end

endmodule : slave_decoder

`default_nettype wire

// File: master_mux.sv
`timescale 1ns/1ps
`default_nettype none

module master_mux (
  input  bus_pkg::bus_state_t  bus_state,
  input  bus_pkg::wb_req_t     m0_req,
  input  bus_pkg::wb_req_t     m1_req,
  input  bus_pkg::wb_rsp_t     bus_rsp,
  output bus_pkg::wb_req_t     bus_req,
  output bus_pkg::wb_rsp_t     m0_rsp,
  output bus_pkg::wb_rsp_t     m1_rsp
);

  logic sel0;
  logic sel1;

  // one-hot view of the owner
  assign sel0 = bus_state.granted & ~bus_state.master;
  assign sel1 = bus_state.granted & bus_state.master;

  //////////////////////////////////////////////////////////////////////
  // request path, owner onto shared bus
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_req = '0;
    if (sel0) begin
      bus_req = m0_req;
    end else if (sel1) begin
      bus_req = m1_req;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response path, owner only
  //////////////////////////////////////////////////////////////////////

  // idle master sees all zeros
  assign m0_rsp = sel0 ? bus_rsp : '0;
  assign m1_rsp = sel1 ? bus_rsp : '0;

endmodule : master_mux

`default_nettype wire

// File: bus_arbiter_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_ctrl (
  input  logic                 clk,
  input  logic                 rstN,
  // both masters, watched for cyc/stb
  input  bus_pkg::wb_req_t     m0_req,
  input  bus_pkg::wb_req_t     m1_req,
  // shared response, marks end of transfer
  input  bus_pkg::wb_rsp_t     bus_rsp,
  // registered select word for the muxes
  output bus_pkg::bus_state_t  bus_state
);

  bus_pkg::arb_state_t state;
  bus_pkg::arb_state_t next_state;

  logic req0;
  logic req1;
  logic any_req;
  logic pick;
  logic last_served;
  logic done;

  //////////////////////////////////////////////////////////////////////
  // request sampling and round robin pick
  //////////////////////////////////////////////////////////////////////

  assign req0 = m0_req.cyc & m0_req.stb;
  assign req1 = m1_req.cyc & m1_req.stb;
  assign any_req = req0 | req1;

  // both asking: whoever was not served last
  // one asking: that one
  assign pick = (req0 && req1) ? ~last_served : req1;

  // transfer over on either ack or err
  assign done = bus_rsp.ack | bus_rsp.err;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state = state;
    unique case (state)
      bus_pkg::IDLE: begin
        if (any_req) begin
          next_state = bus_pkg::GRANT;
        end
      end
      // slave sees strobe during this cycle
      bus_pkg::GRANT: begin
        next_state = bus_pkg::BUSY;
      end
      // wait for the slave or decoder to answer
      bus_pkg::BUSY: begin
        if (done) begin
          next_state = bus_pkg::RELEASE;
        end
      end
      // one dead cycle so the served master drops stb
      bus_pkg::RELEASE: begin
        next_state = bus_pkg::IDLE;
      end
      default: begin
        next_state = bus_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= bus_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // select word and last served
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bus_state <= '0;
      // master 0 wins the first tie
      last_served <= 1'b1;
    end else begin
      if (state == bus_pkg::IDLE && any_req) begin
        bus_state.granted <= 1'b1;
        bus_state.master <= pick;
        last_served <= pick;
      end else if (state == bus_pkg::BUSY && done) begin
        // free the bus on the answering edge
        bus_state <= '0;
      end
    end
  end

endmodule : bus_arbiter_ctrl

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;
  // upper address bits pick the slave
  localparam int SLV_W = 2;
  // lower address bits pick the word
  localparam int OFS_W = 6;
  // ids 1..3 mapped, id 0 answers with err
  localparam int NUM_SLAVES = 3;
  localparam int NUM_WORDS = 2 ** OFS_W;

  //////////////////////////////////////////////////////////////////////
  // bus words
  //////////////////////////////////////////////////////////////////////

  // address seen whole by masters, split by decoder and slaves
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [SLV_W-1:0] slv;
      logic [OFS_W-1:0] ofs;
    } f;
  } bus_addr_u;

  // wishbone classic request, master to slave
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    bus_addr_u adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  // wishbone classic response, slave to master
  typedef struct packed {
    logic ack;
    logic err;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  // mux selects from the controller
  // slave = target id of the granted transfer
  typedef struct packed {
    logic granted;
    logic [SLV_W-1:0] slave;
    logic master;
  } bus_state_t;

  typedef enum logic [1:0] {
    IDLE,
    GRANT,
    BUSY,
    RELEASE
  } arb_state_t;

endpackage : bus_pkg

`default_nettype wire
